// ==== src.f ====
+incdir+test
source/core_pkg.sv
source/inst_decode.sv
source/reg_manage.sv
source/inst_window.sv
source/alu_exec.sv
source/core_slice.sv
test/tb_core_slice.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_core_slice -f src.f

out=$(./obj_dir/Vtb_core_slice 2>&1) || true
echo "$out"

# pass only when the testbench printed its pass line
echo "$out" | grep -qF '*** PASSED ***'

// ==== test/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// reference register file in program order, expected writebacks per rd
logic [31:0] model_regs [32];
logic [31:0] exp_q [32][$];
int          outstanding;

function automatic logic [2:0] funct3_of(input alu_op_e op);
    case (op)
        SLL:     return 3'b001;
        SLT:     return 3'b010;
        SLTU:    return 3'b011;
        XOR:     return 3'b100;
        SRL,
        SRA:     return 3'b101;
        OR:      return 3'b110;
        AND:     return 3'b111;
        default: return 3'b000;
    endcase
endfunction

function automatic logic [31:0] encode_r(input alu_op_e op, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [4:0] rs2);
    logic [6:0] funct7;
    funct7 = (op == SUB || op == SRA) ? 7'b0100000 : 7'b0000000;
    return {funct7, rs2, rs1, funct3_of(op), rd, 7'b0110011};
endfunction

// shifts keep only the shift amount plus the SRA marker
function automatic logic [31:0] encode_i(input alu_op_e op, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [11:0] imm);
    logic [11:0] field;
    field = imm;
    if (op == SLL || op == SRL) begin
        field = {7'b0000000, imm[4:0]};
    end
    if (op == SRA) begin
        field = {7'b0100000, imm[4:0]};
    end
    return {field, rs1, funct3_of(op), rd, 7'b0010011};
endfunction

function automatic logic [31:0] alu_ref(input alu_op_e op, input logic [31:0] a,
                                        input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
        ADD:     return a + b;
        SUB:     return a - b;
        SLL:     return a << sh;
        // differing signs decide by the sign of a alone
        SLT:     return {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
        SLTU:    return {31'b0, a < b};
        XOR:     return a ^ b;
        SRL:     return a >> sh;
        SRA:     return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
        OR:      return a | b;
        AND:     return a & b;
        default: return 32'h0;
    endcase
endfunction

function automatic void expect_result(input logic [4:0] rd, input logic [31:0] value);
    exp_q[rd].push_back(value);
    if (rd != 5'd0) begin
        model_regs[rd] = value;
    end
    outstanding++;
endfunction

`endif

// ==== test/tb_core_slice.sv ====
module tb_core_slice import core_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 2000;

    logic        clk;
    logic        arst_n;
    logic        inst_valid;
    logic        inst_ready;
    logic [31:0] inst;
    logic        wb_valid;
    logic        wb_ready = 1'b0;
    write_d_r_t  wb;
    logic        bp_on;
    logic [31:0] seen_regs [32];

    `include "tb_model.svh"

    core_slice DUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst       (inst),
        .wb_valid   (wb_valid),
        .wb_ready   (wb_ready),
        .wb         (wb)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run();
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    function automatic logic [31:0] rand_word();
        return $urandom();
    endfunction

    // random stall on the writeback port while bp_on is set
    // wb_valid and wb hold until the next rising edge, where the transfer happens
    always @(negedge clk) begin
        wb_ready = bp_on ? ((rand_word() % 3) != 0) : 1'b1;
        if (arst_n && wb_valid && wb_ready) begin
            if (exp_q[wb.rd].size() == 0) begin
                $display("unexpected writeback to x%0d at %0t ns", wb.rd, $time);
                fail_run();
            end else begin
                check($sformatf("wb.d_rd (x%0d)", wb.rd), wb.d_rd, exp_q[wb.rd].pop_front());
                if (wb.rd != 5'd0) begin
                    seen_regs[wb.rd] = wb.d_rd;
                end
                outstanding--;
            end
        end
    end

    // called on a falling edge, returns on a falling edge
    task automatic send_inst(input logic [31:0] word);
        int waited;
        waited = 0;
        inst_valid = 1'b1;
        inst       = word;
        // inst_ready only moves on the rising edge
        while (!inst_ready) begin
            waited++;
            if (waited > TIMEOUT) begin
                $display("inst_ready stayed low for %0d cycles", TIMEOUT);
                fail_run();
            end
            @(negedge clk);
        end
        @(negedge clk);
        inst_valid = 1'b0;
    endtask

    task automatic issue_r(input alu_op_e op, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [4:0] rs2);
        expect_result(rd, alu_ref(op, model_regs[rs1], model_regs[rs2]));
        send_inst(encode_r(op, rd, rs1, rs2));
    endtask

    task automatic issue_i(input alu_op_e op, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [11:0] imm);
        logic [31:0] word;
        word = encode_i(op, rd, rs1, imm);
        expect_result(rd, alu_ref(op, model_regs[rs1], {{20{word[31]}}, word[31:20]}));
        send_inst(word);
    endtask

    // full 32-bit constant from 11/11/10-bit pieces
    task automatic load_word(input logic [4:0] rd, input logic [31:0] value);
        issue_i(ADD, rd, 5'd0, {1'b0, value[31:21]});
        issue_i(SLL, rd, rd, 12'd11);
        issue_i(OR, rd, rd, {1'b0, value[20:10]});
        issue_i(SLL, rd, rd, 12'd10);
        issue_i(OR, rd, rd, {2'b0, value[9:0]});
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (outstanding != 0) begin
            waited++;
            if (waited > TIMEOUT) begin
                $display("%0d writebacks still missing after %0d cycles", outstanding, TIMEOUT);
                fail_run();
            end
            @(negedge clk);
        end
    endtask

    task automatic compare_regs(input int last);
        for (int i = 1; i <= last; i++) begin
            check($sformatf("x%0d", i), seen_regs[i], model_regs[i]);
        end
    endtask

    task automatic reset_and_chain();
        logic [31:0] r;
        check("inst_ready", 32'(inst_ready), 32'd1);
        check("wb_valid", 32'(wb_valid), 32'd0);
        for (int i = 1; i <= 8; i++) begin
            r = rand_word();
            issue_i(ADD, 5'(i), 5'(i - 1), r[11:0]);
        end
        wait_drain();
        compare_regs(8);
    endtask

    task automatic all_ops();
        alu_op_e     op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        for (int k = 0; k < 10; k++) begin
            op = alu_op_e'(4'(k));
            for (int it = 0; it < 3; it++) begin
                a = rand_word();
                b = rand_word();
                r = rand_word();
                // shift by 31 and opposite signs for the compares
                if (it == 0) begin
                    a[31]   = 1'b1;
                    b[31]   = 1'b0;
                    b[4:0]  = 5'h1f;
                    r[4:0]  = 5'h1f;
                end
                if (it == 1) begin
                    a[31] = 1'b0;
                    b[31] = 1'b1;
                end
                load_word(5'd5, a);
                load_word(5'd6, b);
                issue_r(op, 5'd7, 5'd5, 5'd6);
                if (op != SUB) begin
                    issue_i(op, 5'd8, 5'd5, r[11:0]);
                end
            end
        end
        wait_drain();
    endtask

    task automatic dep_chain();
        logic [31:0] r;
        logic [4:0]  prev;
        logic [4:0]  rd;
        alu_op_e     op;
        prev = 5'd1;
        for (int i = 0; i < 16; i++) begin
            r  = rand_word();
            op = alu_op_e'(4'(r[31:16] % 10));
            rd = 5'(10 + i % 4);
            issue_r(op, rd, prev, 5'(1 + r[2:0]));
            prev = rd;
            if (i % 2 == 1) begin
                issue_i(XOR, 5'(20 + i % 3), 5'(1 + r[5:3]), r[27:16]);
            end
        end
        wait_drain();
        compare_regs(31);
    endtask

    task automatic backpressure_stream();
        logic [31:0] r;
        alu_op_e     op;
        bp_on = 1'b1;
        for (int i = 0; i < 80; i++) begin
            r  = rand_word();
            op = alu_op_e'(4'(r[31:24] % 10));
            if (r[23]) begin
                issue_r(op, 5'(1 + r[3:0] % 15), 5'(r[7:4]), 5'(r[11:8]));
            end else begin
                issue_i((op == SUB) ? ADD : op, 5'(1 + r[3:0] % 15), 5'(r[7:4]), r[22:11]);
            end
        end
        wait_drain();
        bp_on = 1'b0;
        compare_regs(31);
    endtask

    task automatic other_opcodes_and_x0();
        logic [31:0] r;
        logic [6:0]  opcodes [3];
        // load, store, branch
        opcodes = '{7'b0000011, 7'b0100011, 7'b1100011};
        for (int i = 0; i < 6; i++) begin
            r = rand_word();
            issue_i(ADD, 5'(1 + i), 5'(1 + i), r[11:0]);
            send_inst({r[31:7], opcodes[i % 3]});
        end
        wait_drain();
        issue_i(ADD, 5'd0, 5'd1, 12'h123);
        wait_drain();
        issue_r(XOR, 5'd0, 5'd2, 5'd3);
        wait_drain();
        issue_r(ADD, 5'd9, 5'd0, 5'd4);
        issue_i(OR, 5'd10, 5'd0, 12'h000);
        wait_drain();
        check("x10", seen_regs[10], 32'd0);
        check("x9", seen_regs[9], model_regs[4]);
    endtask

    // nothing left in flight once every writeback is in
    task automatic drain_check();
        repeat (20) begin
            @(negedge clk);
            check("wb_valid", 32'(wb_valid), 32'd0);
            check("inst_ready", 32'(inst_ready), 32'd1);
        end
    endtask

    initial begin
        void'($urandom(32'h19734c8d));
        arst_n      = 1'b0;
        inst_valid  = 1'b0;
        inst        = '0;
        bp_on       = 1'b0;
        outstanding = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
            seen_regs[i]  = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        reset_and_chain();
        all_ops();
        dep_chain();
        backpressure_stream();
        other_opcodes_and_x0();
        drain_check();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== source/core_slice.sv ====
module core_slice import core_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                inst_valid,
    output logic                inst_ready,
    input  logic [LEN_WORD-1:0] inst,
    output logic                wb_valid,
    input  logic                wb_ready,
    output write_d_r_t          wb
);

    logic                    dec_valid;
    logic                    dec_ready;
    dec_exec_info_t          dec;
    logic                    iss_valid;
    logic                    iss_ready;
    exec_info_t              iss;
    read_req_t               read_req;
    read_rsp_t               read_rsp;
    logic [LEN_REG_ADDR-1:0] rd_check;
    logic                    rd_busy;
    logic                    set_busy;
    logic [LEN_REG_ADDR-1:0] set_rd;
    logic                    wb_fire;

    // writeback broadcast to window and register file
    assign wb_fire = wb_valid && wb_ready;

    inst_decode u_decode (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst       (inst),
        .dec_valid  (dec_valid),
        .dec_ready  (dec_ready),
        .dec        (dec)
    );

    inst_window u_window (
        .clk       (clk),
        .arst_n    (arst_n),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec       (dec),
        .read_req  (read_req),
        .read_rsp  (read_rsp),
        .rd_check  (rd_check),
        .rd_busy   (rd_busy),
        .set_busy  (set_busy),
        .set_rd    (set_rd),
        .wb_fire   (wb_fire),
        .wb        (wb),
        .iss_valid (iss_valid),
        .iss_ready (iss_ready),
        .iss       (iss)
    );

    reg_manage u_regs (
        .clk      (clk),
        .arst_n   (arst_n),
        .read_req (read_req),
        .read_rsp (read_rsp),
        .rd_check (rd_check),
        .rd_busy  (rd_busy),
        .set_busy (set_busy),
        .set_rd   (set_rd),
        .wb_fire  (wb_fire),
        .wb       (wb)
    );

    alu_exec u_exec (
        .clk       (clk),
        .arst_n    (arst_n),
        .iss_valid (iss_valid),
        .iss_ready (iss_ready),
        .iss       (iss),
        .wb_valid  (wb_valid),
        .wb_ready  (wb_ready),
        .wb        (wb)
    );

endmodule

// ==== source/alu_exec.sv ====
module alu_exec import core_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       iss_valid,
    output logic       iss_ready,
    input  exec_info_t iss,
    output logic       wb_valid,
    input  logic       wb_ready,
    output write_d_r_t wb
);

    logic                 s1_valid;
    exec_info_t           s1;
    logic                 s2_adv;
    logic [LEN_SHAMT-1:0] shamt;
    logic [LEN_WORD-1:0]  result;

    // last stage holds under back-pressure, stage one may still fill
    assign s2_adv    = !wb_valid || wb_ready;
    assign iss_ready = !s1_valid || s2_adv;
    assign shamt     = s1.d_b[LEN_SHAMT-1:0];

    always_comb begin
        case (s1.op)
            ADD:     result = s1.d_a + s1.d_b;
            SUB:     result = s1.d_a - s1.d_b;
            SLL:     result = s1.d_a << shamt;
            SLT:     result = {{(LEN_WORD-1){1'b0}}, $signed(s1.d_a) < $signed(s1.d_b)};
            SLTU:    result = {{(LEN_WORD-1){1'b0}}, s1.d_a < s1.d_b};
            XOR:     result = s1.d_a ^ s1.d_b;
            SRL:     result = s1.d_a >> shamt;
            SRA:     result = $unsigned($signed(s1.d_a) >>> shamt);
            OR:      result = s1.d_a | s1.d_b;
            AND:     result = s1.d_a & s1.d_b;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            if (iss_ready) begin
                s1_valid <= iss_valid;
            end
            if (s2_adv) begin
                wb_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid && iss_ready) begin
            s1 <= iss;
        end
        if (s1_valid && s2_adv) begin
            wb <= '{rd: s1.rd, d_rd: result};
        end
    end

    a_wb_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb)
    );

endmodule

// ==== source/inst_window.sv ====
module inst_window import core_pkg::*; (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    dec_valid,
    output logic                    dec_ready,
    input  dec_exec_info_t          dec,
    output read_req_t               read_req,
    input  read_rsp_t               read_rsp,
    output logic [LEN_REG_ADDR-1:0] rd_check,
    input  logic                    rd_busy,
    output logic                    set_busy,
    output logic [LEN_REG_ADDR-1:0] set_rd,
    input  logic                    wb_fire,
    input  write_d_r_t              wb,
    output logic                    iss_valid,
    input  logic                    iss_ready,
    output exec_info_t              iss
);

    // tag is the source register number while rdy is low
    typedef struct packed {
        logic                    rdy;
        logic [LEN_REG_ADDR-1:0] tag;
        logic [LEN_WORD-1:0]     d;
    } operand_t;

    typedef struct packed {
        alu_op_e                 op;
        logic [LEN_REG_ADDR-1:0] rd;
        logic [WIN_IDX_W-1:0]    age;
        operand_t                a;
        operand_t                b;
    } entry_t;

    entry_t               ent [WIN_DEPTH];
    logic [WIN_DEPTH-1:0] ent_valid;
    logic                 free_found;
    logic [WIN_IDX_W-1:0] free_idx;
    logic [WIN_IDX_W:0]   valid_cnt;
    logic [WIN_IDX_W:0]   new_age;
    logic [WIN_IDX_W-1:0] iss_idx;
    logic [WIN_IDX_W-1:0] best_age;
    logic                 dispatch;
    logic                 iss_fire;
    logic                 rd_pending;
    operand_t             new_a;
    operand_t             new_b;

    assign read_req  = '{rs1: dec.rs1, rs2: dec.rs2};
    assign rd_check  = dec.rd;
    assign dec_ready = free_found && !rd_busy;
    assign dispatch  = dec_valid && dec_ready;
    assign set_busy  = dispatch && (dec.rd != '0);
    assign set_rd    = dec.rd;
    assign iss_fire  = iss_valid && iss_ready;

    // lowest free slot and occupancy
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        valid_cnt  = '0;
        for (int i = WIN_DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                free_found = 1'b1;
                free_idx   = WIN_IDX_W'(i);
            end
            valid_cnt = valid_cnt + (WIN_IDX_W + 1)'(ent_valid[i]);
        end
    end

    // an entry still in the window writing the same rd
    always_comb begin
        rd_pending = 1'b0;
        for (int i = 0; i < WIN_DEPTH; i++) begin
            if (ent_valid[i] && (ent[i].rd == dec.rd) && (dec.rd != '0)) begin
                rd_pending = 1'b1;
            end
        end
    end

    // age 0 is the oldest entry
    assign new_age = valid_cnt - (WIN_IDX_W + 1)'(iss_fire);

    always_comb begin
        iss_valid = 1'b0;
        iss_idx   = '0;
        best_age  = '0;
        for (int i = 0; i < WIN_DEPTH; i++) begin
            if (ent_valid[i] && ent[i].a.rdy && ent[i].b.rdy &&
                (!iss_valid || ent[i].age < best_age)) begin
                iss_valid = 1'b1;
                iss_idx   = WIN_IDX_W'(i);
                best_age  = ent[i].age;
            end
        end
    end

    assign iss = '{op: ent[iss_idx].op, rd: ent[iss_idx].rd,
                   d_a: ent[iss_idx].a.d, d_b: ent[iss_idx].b.d};

    always_comb begin
        new_a = '{rdy: read_rsp.rs1.ready, tag: dec.rs1, d: read_rsp.rs1.d};
        if (dec.exec_type == ALU_IMM) begin
            new_b = '{rdy: 1'b1, tag: '0, d: dec.imm};
        end else begin
            new_b = '{rdy: read_rsp.rs2.ready, tag: dec.rs2, d: read_rsp.rs2.d};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ent_valid <= '0;
        end else begin
            if (iss_fire) begin
                ent_valid[iss_idx] <= 1'b0;
            end
            if (dispatch) begin
                ent_valid[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < WIN_DEPTH; i++) begin
            // snoop writeback for pending sources
            if (wb_fire && !ent[i].a.rdy && (ent[i].a.tag == wb.rd)) begin
                ent[i].a.rdy <= 1'b1;
                ent[i].a.d   <= wb.d_rd;
            end
            if (wb_fire && !ent[i].b.rdy && (ent[i].b.tag == wb.rd)) begin
                ent[i].b.rdy <= 1'b1;
                ent[i].b.d   <= wb.d_rd;
            end
            // younger entries close the gap
            if (iss_fire && (ent[i].age > best_age)) begin
                ent[i].age <= ent[i].age - 1'b1;
            end
        end
        if (dispatch) begin
            ent[free_idx] <= '{op: dec.op, rd: dec.rd, age: new_age[WIN_IDX_W-1:0],
                               a: new_a, b: new_b};
        end
    end

    // ages of the valid entries stay below occupancy
    a_issue_age: assert property (
        @(posedge clk) disable iff (!arst_n)
        iss_fire |-> (ent[iss_idx].age < valid_cnt)
    );

    // busy tracking must cover every rd held in the window
    a_no_waw: assert property (
        @(posedge clk) disable iff (!arst_n)
        dispatch |-> !rd_pending
    );

endmodule

// ==== source/reg_manage.sv ====
module reg_manage import core_pkg::*; (
    input  logic                    clk,
    input  logic                    arst_n,
    input  read_req_t               read_req,
    output read_rsp_t               read_rsp,
    input  logic [LEN_REG_ADDR-1:0] rd_check,
    output logic                    rd_busy,
    input  logic                    set_busy,
    input  logic [LEN_REG_ADDR-1:0] set_rd,
    input  logic                    wb_fire,
    input  write_d_r_t              wb
);

    logic [LEN_WORD-1:0] regs [NUM_REGS];
    logic [NUM_REGS-1:0] busy;

    // a writeback in this cycle counts as ready, x0 excluded
    function automatic src_rsp_t read_src(input logic [LEN_REG_ADDR-1:0] addr);
        src_rsp_t rsp;
        logic     hit;
        hit       = wb_fire && (wb.rd == addr) && (addr != '0);
        rsp.ready = !busy[addr] || hit;
        rsp.d     = hit ? wb.d_rd : regs[addr];
        return rsp;
    endfunction

    always_comb begin
        read_rsp.rs1 = read_src(read_req.rs1);
        read_rsp.rs2 = read_src(read_req.rs2);
    end

    assign rd_busy = busy[rd_check];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb_fire) begin
                busy[wb.rd] <= 1'b0;
                if (wb.rd != '0) begin
                    regs[wb.rd] <= wb.d_rd;
                end
            end
            if (set_busy && (set_rd != '0)) begin
                busy[set_rd] <= 1'b1;
            end
        end
    end

    // window waits for rd to drain before dispatch
    a_no_double_busy: assert property (
        @(posedge clk) disable iff (!arst_n)
        set_busy |-> !busy[set_rd]
    );

endmodule

// ==== source/inst_decode.sv ====
module inst_decode import core_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                inst_valid,
    output logic                inst_ready,
    input  logic [LEN_WORD-1:0] inst,
    output logic                dec_valid,
    input  logic                dec_ready,
    output dec_exec_info_t      dec
);

    logic           is_op;
    logic           is_imm;
    logic           is_alu;
    dec_exec_info_t dec_d;

    assign is_op  = (inst[6:0] == OPC_OP);
    assign is_imm = (inst[6:0] == OPC_OP_IMM);
    assign is_alu = is_op || is_imm;

    // free when empty or draining this cycle
    assign inst_ready = !dec_valid || dec_ready;

    always_comb begin
        dec_d.exec_type = is_imm ? ALU_IMM : ALU_STD;
        dec_d.rs1       = inst[19:15];
        dec_d.rs2       = inst[24:20];
        dec_d.rd        = inst[11:7];
        // shift amount of OP-IMM sits in imm[4:0]
        dec_d.imm       = {{(LEN_WORD-12){inst[31]}}, inst[31:20]};
        case (inst[14:12])
            3'b000:  dec_d.op = (is_op && inst[30]) ? SUB : ADD;
            3'b001:  dec_d.op = SLL;
            3'b010:  dec_d.op = SLT;
            3'b011:  dec_d.op = SLTU;
            3'b100:  dec_d.op = XOR;
            3'b101:  dec_d.op = inst[30] ? SRA : SRL;
            3'b110:  dec_d.op = OR;
            default: dec_d.op = AND;
        endcase
    end

    // other opcodes are taken and dropped
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
        end else if (inst_ready) begin
            dec_valid <= inst_valid && is_alu;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid && inst_ready && is_alu) begin
            dec <= dec_d;
        end
    end

endmodule

// ==== source/core_pkg.sv ====
package core_pkg;

    localparam int LEN_WORD     = 32;
    localparam int LEN_REG_ADDR = 5;
    localparam int LEN_SHAMT    = 5;
    localparam int NUM_REGS     = 32;
    localparam int WIN_DEPTH    = 4;
    localparam int WIN_IDX_W    = $clog2(WIN_DEPTH);

    // major opcodes handled by the slice
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } alu_op_e;

    typedef enum logic {
        ALU_STD,
        ALU_IMM
    } exec_type_e;

    // decode -> inst_window
    typedef struct packed {
        exec_type_e              exec_type;
        alu_op_e                 op;
        logic [LEN_REG_ADDR-1:0] rs1;
        logic [LEN_REG_ADDR-1:0] rs2;
        logic [LEN_REG_ADDR-1:0] rd;
        logic [LEN_WORD-1:0]     imm;
    } dec_exec_info_t;

    // inst_window -> alu_exec
    typedef struct packed {
        alu_op_e                 op;
        logic [LEN_REG_ADDR-1:0] rd;
        logic [LEN_WORD-1:0]     d_a;
        logic [LEN_WORD-1:0]     d_b;
    } exec_info_t;

    // alu_exec -> reg_manage, inst_window, top port
    typedef struct packed {
        logic [LEN_REG_ADDR-1:0] rd;
        logic [LEN_WORD-1:0]     d_rd;
    } write_d_r_t;

    typedef struct packed {
        logic [LEN_REG_ADDR-1:0] rs1;
        logic [LEN_REG_ADDR-1:0] rs2;
    } read_req_t;

    typedef struct packed {
        logic                ready;
        logic [LEN_WORD-1:0] d;
    } src_rsp_t;

    typedef struct packed {
        src_rsp_t rs1;
        src_rsp_t rs2;
    } read_rsp_t;

endpackage
